// File: logic/gs_div_pkg.sv
package gs_div_pkg;

   //////////////////////////////
   // schedule steps
   //////////////////////////////

   typedef enum logic [3:0]
   {
      PH_IDLE       = 4'd0,
      PH_LAUNCH     = 4'd1,
      PH_SETUP      = 4'd2,
      PH_ITER_SCALE = 4'd3,  // first half of a pair
      PH_ITER_RECIP = 4'd4,  // second half of a pair
      PH_DRAIN      = 4'd5,
      PH_QUOTIENT   = 4'd6,
      PH_REM_SELECT = 4'd7,
      PH_REM_LOAD   = 4'd8,
      PH_SETTLE     = 4'd9,
      PH_DONE       = 4'd10,
      PH_TAIL       = 4'd11
   } phase_t;

   //////////////////////////////
   // operand mux selects
   //////////////////////////////

   typedef logic [1:0] sel_t;

   // operand a mux
   localparam sel_t SEL_A_ITER   = 2'd0;
   localparam sel_t SEL_A_SETUP  = 2'd1;
   localparam sel_t SEL_A_LAUNCH = 2'd2;
   localparam sel_t SEL_A_RECIP  = 2'd3;

   // operand b mux
   localparam sel_t SEL_B_LAUNCH = 2'd0;
   localparam sel_t SEL_B_SETUP  = 2'd1;
   localparam sel_t SEL_B_ITER   = 2'd2;
   localparam sel_t SEL_B_RECIP  = 2'd3;

   //////////////////////////////
   // iteration pair counts
   //////////////////////////////

   localparam int ITER_DOUBLE_DEFAULT = 3;  // 53-bit significand
   localparam int ITER_SINGLE_DEFAULT = 2;  // 24-bit significand

endpackage

// File: logic/gs_phase_sequencer.sv
module gs_phase_sequencer #(
   parameter int ITER_DOUBLE = gs_div_pkg::ITER_DOUBLE_DEFAULT,
   parameter int ITER_SINGLE = gs_div_pkg::ITER_SINGLE_DEFAULT
)(
   input  logic              clk,
   input  logic              reset,
   input  logic              start,
   input  logic              precision,
   output gs_div_pkg::phase_t step
);

   localparam int ITER_MAX = (ITER_DOUBLE > ITER_SINGLE) ? ITER_DOUBLE : ITER_SINGLE;
   localparam int CNT_W    = (ITER_MAX > 1) ? $clog2(ITER_MAX) : 1;

   gs_div_pkg::phase_t phase;       // registered step
   gs_div_pkg::phase_t next_phase;
   logic               prec_single; // precision seen at launch
   logic [CNT_W-1:0]   pair_cnt;    // completed pairs
   logic [CNT_W-1:0]   last_idx;
   logic               pair_last;

   //////////////////////////////
   // current step
   //////////////////////////////

   // launch happens in the accept cycle itself
   always_comb
   begin
      if (phase == gs_div_pkg::PH_IDLE && start)
         step = gs_div_pkg::PH_LAUNCH;
      else
         step = phase;
   end

   assign last_idx  = prec_single ? CNT_W'(ITER_SINGLE - 1) : CNT_W'(ITER_DOUBLE - 1);
   assign pair_last = (pair_cnt == last_idx);

   //////////////////////////////
   // next step
   //////////////////////////////

   always_comb
   begin
      case (step)
         gs_div_pkg::PH_LAUNCH:     next_phase = gs_div_pkg::PH_SETUP;
         gs_div_pkg::PH_SETUP:      next_phase = gs_div_pkg::PH_ITER_SCALE;
         gs_div_pkg::PH_ITER_SCALE: next_phase = gs_div_pkg::PH_ITER_RECIP;
         gs_div_pkg::PH_ITER_RECIP:
         begin
            if (pair_last)
               next_phase = gs_div_pkg::PH_DRAIN;
            else
               next_phase = gs_div_pkg::PH_ITER_SCALE;  // another pair
         end
         gs_div_pkg::PH_DRAIN:      next_phase = gs_div_pkg::PH_QUOTIENT;
         gs_div_pkg::PH_QUOTIENT:   next_phase = gs_div_pkg::PH_REM_SELECT;
         gs_div_pkg::PH_REM_SELECT: next_phase = gs_div_pkg::PH_REM_LOAD;
         gs_div_pkg::PH_REM_LOAD:   next_phase = gs_div_pkg::PH_SETTLE;
         gs_div_pkg::PH_SETTLE:     next_phase = gs_div_pkg::PH_DONE;
         gs_div_pkg::PH_DONE:       next_phase = gs_div_pkg::PH_TAIL;
         default:                   next_phase = gs_div_pkg::PH_IDLE;  // idle and tail
      endcase
   end

   //////////////////////////////
   // state registers
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         phase       <= gs_div_pkg::PH_IDLE;
         prec_single <= 1'b0;
         pair_cnt    <= '0;
      end
      else
      begin
         phase <= next_phase;

         if (step == gs_div_pkg::PH_LAUNCH)
            prec_single <= precision;

         if (step == gs_div_pkg::PH_LAUNCH || step == gs_div_pkg::PH_SETUP)
            pair_cnt <= '0;
         else if (step == gs_div_pkg::PH_ITER_RECIP && !pair_last)
            pair_cnt <= pair_cnt + 1'b1;  // count finished pair
      end
   end

endmodule

// File: logic/gs_control_decoder.sv
module gs_control_decoder (
   input  gs_div_pkg::phase_t step,
   output logic               done,
   output logic               busy,
   output logic               load_a,
   output logic               load_b,
   output logic               load_c,
   output logic               load_quot,
   output logic               load_rem,
   output logic               load_prod,
   output gs_div_pkg::sel_t   sel_a,
   output gs_div_pkg::sel_t   sel_b,
   output logic               sel_rem
);

   //////////////////////////////
   // control word per step
   //////////////////////////////

   always_comb
   begin
      done      = 1'b0;
      busy      = 1'b0;
      load_a    = 1'b0;
      load_b    = 1'b0;
      load_c    = 1'b0;
      load_quot = 1'b0;
      load_rem  = 1'b0;
      load_prod = 1'b0;
      sel_a     = gs_div_pkg::SEL_A_ITER;
      sel_b     = gs_div_pkg::SEL_B_LAUNCH;
      sel_rem   = 1'b0;

      case (step)
         gs_div_pkg::PH_LAUNCH:
         begin
            busy      = 1'b1;
            load_prod = 1'b1;
            load_a    = 1'b1;
            load_c    = 1'b1;
            sel_a     = gs_div_pkg::SEL_A_LAUNCH;
            sel_b     = gs_div_pkg::SEL_B_LAUNCH;
         end
         gs_div_pkg::PH_SETUP:
         begin
            busy      = 1'b1;
            load_prod = 1'b1;
            load_b    = 1'b1;  // first reciprocal estimate
            sel_a     = gs_div_pkg::SEL_A_SETUP;
            sel_b     = gs_div_pkg::SEL_B_SETUP;
         end
         gs_div_pkg::PH_ITER_SCALE:
         begin
            busy      = 1'b1;
            load_prod = 1'b1;
            load_a    = 1'b1;
            load_c    = 1'b1;
            sel_a     = gs_div_pkg::SEL_A_ITER;
            sel_b     = gs_div_pkg::SEL_B_ITER;
         end
         gs_div_pkg::PH_ITER_RECIP:
         begin
            busy      = 1'b1;
            load_prod = 1'b1;
            load_b    = 1'b1;  // two minus product
            sel_a     = gs_div_pkg::SEL_A_RECIP;
            sel_b     = gs_div_pkg::SEL_B_RECIP;
         end
         gs_div_pkg::PH_QUOTIENT:
         begin
            busy      = 1'b1;
            load_prod = 1'b1;
            load_quot = 1'b1;
         end
         gs_div_pkg::PH_REM_SELECT:
         begin
            busy      = 1'b1;
            load_prod = 1'b1;
            sel_rem   = 1'b1;
         end
         gs_div_pkg::PH_REM_LOAD:
         begin
            busy      = 1'b1;
            load_prod = 1'b1;
            sel_rem   = 1'b1;
            load_rem  = 1'b1;
         end
         gs_div_pkg::PH_DRAIN,
         gs_div_pkg::PH_SETTLE:
         begin
            busy      = 1'b1;  // pipeline catch-up
            load_prod = 1'b1;
         end
         gs_div_pkg::PH_DONE:
         begin
            load_prod = 1'b1;
            done      = 1'b1;
         end
         default: ;  // idle and tail stay quiet
      endcase
   end

endmodule

// File: logic/gs_div_control.sv
module gs_div_control #(
   parameter int ITER_DOUBLE = gs_div_pkg::ITER_DOUBLE_DEFAULT,
   parameter int ITER_SINGLE = gs_div_pkg::ITER_SINGLE_DEFAULT
)(
   input  logic             clk,
   input  logic             reset,
   input  logic             start,
   input  logic             precision,  // 1 for single
   output logic             done,
   output logic             busy,
   output logic             load_a,
   output logic             load_b,
   output logic             load_c,
   output logic             load_quot,
   output logic             load_rem,
   output logic             load_prod,
   output gs_div_pkg::sel_t sel_a,
   output gs_div_pkg::sel_t sel_b,
   output logic             sel_rem
);

   gs_div_pkg::phase_t step;  // step acted on this cycle

   gs_phase_sequencer #(
      .ITER_DOUBLE (ITER_DOUBLE),
      .ITER_SINGLE (ITER_SINGLE)
   ) sequencer0 (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .precision (precision),
      .step      (step)
   );

   gs_control_decoder decoder0 (
      .step      (step),
      .done      (done),
      .busy      (busy),
      .load_a    (load_a),
      .load_b    (load_b),
      .load_c    (load_c),
      .load_quot (load_quot),
      .load_rem  (load_rem),
      .load_prod (load_prod),
      .sel_a     (sel_a),
      .sel_b     (sel_b),
      .sel_rem   (sel_rem)
   );

endmodule

// File: test/gs_div_control_asserts.sv
module gs_div_control_asserts (
   input logic clk,
   input logic reset,
   input logic done,
   input logic busy,
   input logic load_a,
   input logic load_c
);

   timeunit 1ns;
   timeprecision 100ps;

   //////////////////////////////
   // control output rules
   //////////////////////////////

   done_single_cycle: assert property (@(posedge clk) disable iff (reset)
      !(done && $past(done)))
      else $error("done held for more than one cycle");

   busy_done_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(busy && done))
      else $error("busy and done high together");

   a_c_loads_paired: assert property (@(posedge clk) disable iff (reset)
      load_a == load_c)
      else $error("load_a and load_c disagree");

endmodule

bind gs_div_control gs_div_control_asserts asserts0 (
   .clk    (clk),
   .reset  (reset),
   .done   (done),
   .busy   (busy),
   .load_a (load_a),
   .load_c (load_c)
);

// File: test/gs_div_control_tb.sv
module gs_div_control_tb;

   timeunit 1ns;
   timeprecision 100ps;

   logic clk;
   logic reset;
   logic start;
   logic precision;
   logic done;
   logic busy;
   logic load_a;
   logic load_b;
   logic load_c;
   logic load_quot;
   logic load_rem;
   logic load_prod;
   logic sel_rem;
   gs_div_pkg::sel_t sel_a;
   gs_div_pkg::sel_t sel_b;

   integer seed;
   int     rnd;
   int     gap;

   // reference model state
   logic               model_active;
   int                 model_cycle;  // cycles since accepted start
   int                 model_n;      // iteration pairs
   logic               done_seen;
   int                 done_cycle;
   gs_div_pkg::phase_t exp_step;
   logic               exp_done;
   logic               exp_busy;
   logic               exp_load_a;
   logic               exp_load_b;
   logic               exp_load_c;
   logic               exp_load_quot;
   logic               exp_load_rem;
   logic               exp_load_prod;
   logic               exp_sel_rem;
   gs_div_pkg::sel_t   exp_sel_a;
   gs_div_pkg::sel_t   exp_sel_b;

   gs_div_control dut0 (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .precision (precision),
      .done      (done),
      .busy      (busy),
      .load_a    (load_a),
      .load_b    (load_b),
      .load_c    (load_c),
      .load_quot (load_quot),
      .load_rem  (load_rem),
      .load_prod (load_prod),
      .sel_a     (sel_a),
      .sel_b     (sel_b),
      .sel_rem   (sel_rem)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic stop_with_failure();
      $display("Simulation failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input logic [7:0] actual,
                              input logic [7:0] expected);
      if (actual !== expected)
      begin
         $display("error: %s dut=%h expected=%h", name, actual, expected);
         stop_with_failure();
      end
   endtask

   //////////////////////////////
   // reference model
   //////////////////////////////

   function automatic gs_div_pkg::phase_t expected_step(input int c, input int n);
      gs_div_pkg::phase_t s;
      if (c == 0)
         s = gs_div_pkg::PH_LAUNCH;
      else if (c == 1)
         s = gs_div_pkg::PH_SETUP;
      else if (c <= 2 * n + 1)
         s = (c % 2 == 0) ? gs_div_pkg::PH_ITER_SCALE : gs_div_pkg::PH_ITER_RECIP;
      else if (c == 2 * n + 2)
         s = gs_div_pkg::PH_DRAIN;
      else if (c == 2 * n + 3)
         s = gs_div_pkg::PH_QUOTIENT;
      else if (c == 2 * n + 4)
         s = gs_div_pkg::PH_REM_SELECT;
      else if (c == 2 * n + 5)
         s = gs_div_pkg::PH_REM_LOAD;
      else if (c == 2 * n + 6)
         s = gs_div_pkg::PH_SETTLE;
      else if (c == 2 * n + 7)
         s = gs_div_pkg::PH_DONE;
      else
         s = gs_div_pkg::PH_TAIL;
      return s;
   endfunction

   task automatic set_expected();
      exp_step      = model_active ? expected_step(model_cycle, model_n)
                                   : gs_div_pkg::PH_IDLE;
      exp_done      = (exp_step == gs_div_pkg::PH_DONE);
      exp_load_a    = (exp_step == gs_div_pkg::PH_LAUNCH) ||
                      (exp_step == gs_div_pkg::PH_ITER_SCALE);
      exp_load_c    = exp_load_a;
      exp_load_b    = (exp_step == gs_div_pkg::PH_SETUP) ||
                      (exp_step == gs_div_pkg::PH_ITER_RECIP);
      exp_load_quot = (exp_step == gs_div_pkg::PH_QUOTIENT);
      exp_load_rem  = (exp_step == gs_div_pkg::PH_REM_LOAD);
      exp_sel_rem   = (exp_step == gs_div_pkg::PH_REM_SELECT) || exp_load_rem;
      case (exp_step)
         gs_div_pkg::PH_LAUNCH:     exp_sel_a = gs_div_pkg::SEL_A_LAUNCH;
         gs_div_pkg::PH_SETUP:      exp_sel_a = gs_div_pkg::SEL_A_SETUP;
         gs_div_pkg::PH_ITER_RECIP: exp_sel_a = gs_div_pkg::SEL_A_RECIP;
         default:                   exp_sel_a = gs_div_pkg::SEL_A_ITER;
      endcase
      case (exp_step)
         gs_div_pkg::PH_SETUP:      exp_sel_b = gs_div_pkg::SEL_B_SETUP;
         gs_div_pkg::PH_ITER_SCALE: exp_sel_b = gs_div_pkg::SEL_B_ITER;
         gs_div_pkg::PH_ITER_RECIP: exp_sel_b = gs_div_pkg::SEL_B_RECIP;
         default:                   exp_sel_b = gs_div_pkg::SEL_B_LAUNCH;
      endcase
      // busy and product enable windows
      exp_busy      = model_active && (model_cycle <= 2 * model_n + 6);
      exp_load_prod = model_active && (model_cycle <= 2 * model_n + 7);
   endtask

   task automatic check_outputs();
      check_value("done", 8'(done), 8'(exp_done));
      check_value("busy", 8'(busy), 8'(exp_busy));
      check_value("load_a", 8'(load_a), 8'(exp_load_a));
      check_value("load_b", 8'(load_b), 8'(exp_load_b));
      check_value("load_c", 8'(load_c), 8'(exp_load_c));
      check_value("load_quot", 8'(load_quot), 8'(exp_load_quot));
      check_value("load_rem", 8'(load_rem), 8'(exp_load_rem));
      check_value("load_prod", 8'(load_prod), 8'(exp_load_prod));
      check_value("sel_a", 8'(sel_a), 8'(exp_sel_a));
      check_value("sel_b", 8'(sel_b), 8'(exp_sel_b));
      check_value("sel_rem", 8'(sel_rem), 8'(exp_sel_rem));
   endtask

   //////////////////////////////
   // stimulus
   //////////////////////////////

   // drive, check mid low phase, then advance model
   task automatic run_cycle(input logic st, input logic prec);
      @(negedge clk);
      start     = st;
      precision = prec;
      if (!model_active && st)
      begin
         model_active = 1'b1;  // accepted only while idle
         model_cycle  = 0;
         model_n      = prec ? 2 : 3;
      end
      set_expected();
      #2;
      check_outputs();
      if (done === 1'b1)
      begin
         done_seen  = 1'b1;
         done_cycle = model_cycle;
      end
      if (model_active)
      begin
         model_cycle = model_cycle + 1;
         if (model_cycle == 2 * model_n + 9)
            model_active = 1'b0;
      end
   endtask

   task automatic run_operation(input logic prec, input logic noisy);
      int waited;
      done_seen = 1'b0;
      run_cycle(1'b1, prec);
      waited = 0;
      while (!done_seen)
      begin
         rnd = $random(seed);
         run_cycle(noisy & rnd[0], rnd[1]);  // starts here must be ignored
         waited = waited + 1;
         if (waited > 40)
         begin
            $display("timed out waiting for done");
            stop_with_failure();
         end
      end
      check_value("done_cycle", 8'(done_cycle), prec ? 8'd11 : 8'd13);
      waited = 0;
      while (model_active)
      begin
         rnd = $random(seed);
         run_cycle(noisy & rnd[0], rnd[1]);  // tail cycle
         waited = waited + 1;
         if (waited > 4)
         begin
            $display("timed out waiting for the controller to go idle");
            stop_with_failure();
         end
      end
   endtask

   initial
   begin
      seed         = 97;
      reset        = 1'b1;
      start        = 1'b0;
      precision    = 1'b0;
      model_active = 1'b0;
      model_cycle  = 0;
      model_n      = 3;
      done_seen    = 1'b0;
      done_cycle   = 0;

      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      repeat (10)
      begin
         rnd = $random(seed);
         run_cycle(1'b0, rnd[1]);  // idle, everything quiet
      end

      run_operation(1'b0, 1'b0);  // double
      run_operation(1'b1, 1'b0);  // single
      run_operation(1'b0, 1'b1);
      run_operation(1'b1, 1'b1);

      repeat (40)
      begin
         rnd = $random(seed);
         gap = rnd & 3;
         repeat (gap)
         begin
            rnd = $random(seed);
            run_cycle(1'b0, rnd[1]);
         end
         rnd = $random(seed);
         run_operation(rnd[2], 1'b1);
      end

      $display("Simulation passed");
      $finish;
   end

endmodule

// File: gs_div_control.f
logic/gs_div_pkg.sv
logic/gs_phase_sequencer.sv
logic/gs_control_decoder.sv
logic/gs_div_control.sv
test/gs_div_control_asserts.sv
test/gs_div_control_tb.sv

// File: run.sh
#!/bin/sh
# build and run the Goldschmidt divider control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --timescale 1ns/100ps \
   --top-module gs_div_control_tb \
   -f gs_div_control.f \
   -o gs_div_control_sim

./obj_dir/gs_div_control_sim
